/* verilog/ing_adapt_pkg.sv */
//////////////////////////////////////////////////
// Widths, beat and word structs, counter events and slot names
// shared by all modules of the ingress port array adapter
//////////////////////////////////////////////////

package ing_adapt_pkg;

    //////////////////////////////////////////////////
    // Bus widths

    // Physical port beat and converged bus word sizes in bytes
    localparam int PHY_BYTES      = 2;
    localparam int BUS_BYTES      = 8;
    localparam int BEATS_PER_WORD = BUS_BYTES / PHY_BYTES;

    // Statistics slots per port
    localparam int NUM_CNTS       = 4;
    localparam int BYTE_CNT_W     = $clog2(BUS_BYTES + 1);

    //////////////////////////////////////////////////
    // Structs

    // One beat from a physical receive port
    typedef struct packed {
        logic [PHY_BYTES*8-1:0] data;
        logic [PHY_BYTES-1:0]   keep;
        logic                   last;
    } ing_phy_beat_t;

    // One converged bus word, byte 0 in the low lane
    typedef struct packed {
        logic [BUS_BYTES*8-1:0] data;
        logic [BUS_BYTES-1:0]   keep;
        logic                   last;
    } ing_bus_word_t;

    // Single-cycle statistics event from the frame gate
    typedef struct packed {
        logic                  word_pushed;
        logic [BYTE_CNT_W-1:0] byte_count;
        logic                  frame_done;
        logic                  drop_disabled;
        logic                  drop_full;
    } ing_event_t;

    // Counter slot order within a port
    typedef enum logic [1:0] {
        CNT_FRAMES        = 2'd0,
        CNT_BYTES         = 2'd1,
        CNT_DROP_DISABLED = 2'd2,
        CNT_DROP_FULL     = 2'd3
    } ing_cnt_idx_e;

endpackage

/* verilog/ing_width_upsizer.sv */
//////////////////////////////////////////////////
// Packs 16-bit phy beats into 64-bit bus words, one upsizer per port
// A word leaves when all lanes are filled or the frame ends
//////////////////////////////////////////////////

module ing_width_upsizer (
    input  logic                         ing_phys_ports,
    input  logic                         reset,
    input  logic                         phy_valid,
    input  ing_adapt_pkg::ing_phy_beat_t phy_beat,
    output logic                         word_valid,
    output ing_adapt_pkg::ing_bus_word_t word
);

    import ing_adapt_pkg::*;

    localparam int LANE_W    = $clog2(BEATS_PER_WORD);
    localparam int LANE_BITS = PHY_BYTES * 8;

    // Lane that the next accepted beat lands in
    logic [LANE_W-1:0]      lane;

    // Partially assembled word
    logic [BUS_BYTES*8-1:0] acc_data;
    logic [BUS_BYTES-1:0]   acc_keep;

    // Assembled word including the current beat
    logic [BUS_BYTES*8-1:0] next_data;
    logic [BUS_BYTES-1:0]   next_keep;
    logic                   word_done;

    //////////////////////////////////////////////////
    // Lane merge

    always_comb begin
        next_data = acc_data;
        next_keep = acc_keep;
        next_data[lane*LANE_BITS +: LANE_BITS] = phy_beat.data;
        next_keep[lane*PHY_BYTES +: PHY_BYTES] = phy_beat.keep;
    end

    // Top lane filled or frame ended
    assign word_done = phy_valid &&
                       (phy_beat.last || lane == LANE_W'(BEATS_PER_WORD - 1));

    //////////////////////////////////////////////////
    // Assembly state

    always_ff @(posedge ing_phys_ports) begin
        if (reset) begin
            lane       <= '0;
            acc_data   <= '0;
            acc_keep   <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_done;
            if (word_done) begin
                // Start the next word from empty lanes so unused bytes read as zero
                lane     <= '0;
                acc_data <= '0;
                acc_keep <= '0;
            end else if (phy_valid) begin
                lane     <= lane + 1'b1;
                acc_data <= next_data;
                acc_keep <= next_keep;
            end
        end
    end

    // Output word, loaded once per completed word
    always_ff @(posedge ing_phys_ports) begin
        if (word_done) begin
            word.data <= next_data;
            word.keep <= next_keep;
            word.last <= phy_beat.last;
        end
    end

    //////////////////////////////////////////////////
    // Checks

    // A half-filled beat may only close a frame
    partial_beat_is_last_a : assert property (
        @(posedge ing_phys_ports) disable iff (reset)
        phy_valid && (phy_beat.keep != '1) |-> phy_beat.last
    );

endmodule

/* verilog/ing_frame_gate.sv */
//////////////////////////////////////////////////
// Per-port frame admission control between upsizer and FIFO
// Decides at each frame start and holds that decision to frame end
//////////////////////////////////////////////////

module ing_frame_gate #(
    parameter int FIFO_DEPTH      = 16,
    parameter int MAX_FRAME_WORDS = 4
) (
    input  logic                                ing_phys_ports,
    input  logic                                reset,
    input  logic                                word_valid,
    input  ing_adapt_pkg::ing_bus_word_t        word,
    input  logic                                port_enable,
    input  logic [$clog2(FIFO_DEPTH):0]         free_words,
    output logic                                push,
    output ing_adapt_pkg::ing_bus_word_t        push_word,
    output ing_adapt_pkg::ing_event_t           stat_event,
    output logic                                connected,
    output logic                                buf_full_drop
);

    import ing_adapt_pkg::*;

    // Frame tracking
    logic                  in_frame;
    logic                  admit;
    logic                  frame_start;
    logic                  space_ok;
    logic                  admit_now;
    logic                  take;
    logic                  full_reject;
    logic [BYTE_CNT_W-1:0] keep_ones;

    //////////////////////////////////////////////////
    // Admission rule

    assign frame_start = word_valid && !in_frame;

    // The word pushed last cycle is not yet in free_words
    assign space_ok    = int'(free_words) >= MAX_FRAME_WORDS + int'(push);

    assign admit_now   = in_frame ? admit : (port_enable && space_ok);
    assign take        = word_valid && admit_now;
    assign full_reject = frame_start && port_enable && !space_ok;

    // Bytes carried by the incoming word
    always_comb begin
        keep_ones = '0;
        for (int i = 0; i < BUS_BYTES; i++) begin
            keep_ones = keep_ones + BYTE_CNT_W'(word.keep[i]);
        end
    end

    //////////////////////////////////////////////////
    // Control state and outputs

    always_ff @(posedge ing_phys_ports) begin
        if (reset) begin
            in_frame      <= 1'b0;
            admit         <= 1'b0;
            push          <= 1'b0;
            stat_event    <= '0;
            connected     <= 1'b0;
            buf_full_drop <= 1'b0;
        end else begin
            push                     <= take;
            stat_event.word_pushed   <= take;
            stat_event.byte_count    <= take ? keep_ones : '0;
            stat_event.frame_done    <= take && word.last;
            stat_event.drop_disabled <= frame_start && !port_enable;
            stat_event.drop_full     <= full_reject;
            buf_full_drop            <= full_reject;

            if (word_valid) begin
                in_frame <= !word.last;
            end
            if (frame_start) begin
                admit <= admit_now;
            end
            // Enable is sampled only between frames
            if (!in_frame) begin
                connected <= port_enable;
            end
        end
    end

    always_ff @(posedge ing_phys_ports) begin
        if (take) begin
            push_word <= word;
        end
    end

    //////////////////////////////////////////////////
    // Checks

    // Admission keeps the FIFO from overflowing
    no_push_when_full_a : assert property (
        @(posedge ing_phys_ports) disable iff (reset)
        push |-> free_words != '0
    );

    // A space drop discards the frame from its first word on
    full_drop_discards_a : assert property (
        @(posedge ing_phys_ports) disable iff (reset)
        buf_full_drop |-> !push && !admit
    );

endmodule

/* verilog/ing_frame_fifo.sv */
//////////////////////////////////////////////////
// Show-ahead FIFO of bus words with a registered head and valid/ready drain
//////////////////////////////////////////////////

module ing_frame_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                         ing_phys_ports,
    input  logic                         reset,
    input  logic                         push,
    input  ing_adapt_pkg::ing_bus_word_t push_word,
    output logic [$clog2(FIFO_DEPTH):0]  free_words,
    output logic                         out_valid,
    output ing_adapt_pkg::ing_bus_word_t out_word,
    input  logic                         out_ready
);

    import ing_adapt_pkg::*;

    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FREE_W = PTR_W + 1;

    ing_bus_word_t     mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;

    // Words held in memory, and in memory plus the head register
    logic [FREE_W-1:0] mem_count;
    logic [FREE_W-1:0] occ;

    logic              pop;
    logic              out_free;
    logic              load;
    logic              bypass;
    logic              mem_wr;

    //////////////////////////////////////////////////
    // Head register control

    assign pop      = out_valid && out_ready;
    assign out_free = !out_valid || pop;

    // Refill the head from memory, or straight from the push when memory is empty
    assign load     = out_free && (mem_count != '0);
    assign bypass   = out_free && (mem_count == '0) && push;
    assign mem_wr   = push && !bypass;

    assign free_words = FREE_W'(FIFO_DEPTH) - occ;

    always_ff @(posedge ing_phys_ports) begin
        if (mem_wr) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge ing_phys_ports) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_count <= '0;
            occ       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            mem_count <= mem_count + FREE_W'(mem_wr) - FREE_W'(load);
            occ       <= occ + FREE_W'(push) - FREE_W'(pop);
            if (out_free) begin
                out_valid <= load || bypass;
            end
        end
    end

    always_ff @(posedge ing_phys_ports) begin
        if (load) begin
            out_word <= mem[rd_ptr];
        end else if (bypass) begin
            out_word <= push_word;
        end
    end

    //////////////////////////////////////////////////
    // Checks

    // Held word stays put under back-pressure
    hold_stable_a : assert property (
        @(posedge ing_phys_ports) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_word)
    );

endmodule

/* verilog/ing_port_counters.sv */
//////////////////////////////////////////////////
// Per-port statistics, four wrapping counters fed by gate events
//////////////////////////////////////////////////

module ing_port_counters #(
    parameter int CNT_WIDTH = 32
) (
    input  logic                                                  ing_phys_ports,
    input  logic                                                  reset,
    input  ing_adapt_pkg::ing_event_t                             stat_event,
    input  logic                                                  cnt_clear,
    output logic [ing_adapt_pkg::NUM_CNTS-1:0][CNT_WIDTH-1:0]     counts
);

    import ing_adapt_pkg::*;

    // Per-slot increment for this cycle
    logic [NUM_CNTS-1:0][CNT_WIDTH-1:0] incr;

    //////////////////////////////////////////////////
    // Event decode

    always_comb begin
        incr                    = '0;
        incr[CNT_FRAMES]        = CNT_WIDTH'(stat_event.frame_done);
        incr[CNT_DROP_DISABLED] = CNT_WIDTH'(stat_event.drop_disabled);
        incr[CNT_DROP_FULL]     = CNT_WIDTH'(stat_event.drop_full);
        if (stat_event.word_pushed) begin
            incr[CNT_BYTES] = CNT_WIDTH'(stat_event.byte_count);
        end
    end

    //////////////////////////////////////////////////
    // Counters

    // Clear wins over any increment in the same cycle
    always_ff @(posedge ing_phys_ports) begin
        if (reset || cnt_clear) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < NUM_CNTS; i++) begin
                counts[i] <= counts[i] + incr[i];
            end
        end
    end

endmodule

/* verilog/ing_port_array_adapt.sv */
//////////////////////////////////////////////////
// Ingress port array adapter top, one upsizer, gate, FIFO
// and counter set per physical port
//////////////////////////////////////////////////

module ing_port_array_adapt #(
    parameter int NUM_PORTS       = 2,
    parameter int FIFO_DEPTH      = 16,
    parameter int MAX_FRAME_WORDS = 4,
    parameter int CNT_WIDTH       = 32
) (
    input  logic                                               ing_phys_ports,
    input  logic                                               reset,
    input  logic [NUM_PORTS-1:0]                               phy_valid,
    input  ing_adapt_pkg::ing_phy_beat_t                       phy_beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]                               port_enable,
    input  logic [NUM_PORTS-1:0]                               cnt_clear,
    input  logic [NUM_PORTS-1:0]                               out_ready,
    output logic [NUM_PORTS-1:0]                               out_valid,
    output ing_adapt_pkg::ing_bus_word_t                       out_word [NUM_PORTS],
    output logic [ing_adapt_pkg::NUM_CNTS-1:0][CNT_WIDTH-1:0]  counts [NUM_PORTS],
    output logic [NUM_PORTS-1:0]                               connected,
    output logic [NUM_PORTS-1:0]                               buf_full_drop
);

    import ing_adapt_pkg::*;

    // FIFO depth must be a power of two and hold at least one frame
    if ((FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0 || FIFO_DEPTH < MAX_FRAME_WORDS) begin : g_bad_cfg
        $error("FIFO_DEPTH must be a power of two no smaller than MAX_FRAME_WORDS");
    end

    //////////////////////////////////////////////////
    // Per-port pipelines

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic                      word_valid;
        ing_bus_word_t             word;
        logic                      push;
        ing_bus_word_t             push_word;
        logic [$clog2(FIFO_DEPTH):0] free_words;
        ing_event_t                stat_event;

        ing_width_upsizer u_upsizer (
            .ing_phys_ports (ing_phys_ports),
            .reset          (reset),
            .phy_valid      (phy_valid[p]),
            .phy_beat       (phy_beat[p]),
            .word_valid     (word_valid),
            .word           (word)
        );

        ing_frame_gate #(
            .FIFO_DEPTH      (FIFO_DEPTH),
            .MAX_FRAME_WORDS (MAX_FRAME_WORDS)
        ) u_gate (
            .ing_phys_ports (ing_phys_ports),
            .reset          (reset),
            .word_valid     (word_valid),
            .word           (word),
            .port_enable    (port_enable[p]),
            .free_words     (free_words),
            .push           (push),
            .push_word      (push_word),
            .stat_event     (stat_event),
            .connected      (connected[p]),
            .buf_full_drop  (buf_full_drop[p])
        );

        ing_frame_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .ing_phys_ports (ing_phys_ports),
            .reset          (reset),
            .push           (push),
            .push_word      (push_word),
            .free_words     (free_words),
            .out_valid      (out_valid[p]),
            .out_word       (out_word[p]),
            .out_ready      (out_ready[p])
        );

        ing_port_counters #(
            .CNT_WIDTH (CNT_WIDTH)
        ) u_counters (
            .ing_phys_ports (ing_phys_ports),
            .reset          (reset),
            .stat_event     (stat_event),
            .cnt_clear      (cnt_clear[p]),
            .counts         (counts[p])
        );
    end

endmodule

/* dv/ing_adapt_tb.sv */
//////////////////////////////////////////////////
// Testbench for the ingress port array adapter, random frames
// per port checked against a packing and admission model
//////////////////////////////////////////////////

module ing_adapt_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import ing_adapt_pkg::*;

    localparam int NUM_PORTS       = 2;
    localparam int FIFO_DEPTH      = 16;
    localparam int MAX_FRAME_WORDS = 4;
    localparam int CNT_WIDTH       = 32;

    // One driver slot per cycle, first_done marks the beat that completes word 0
    typedef struct packed {
        logic          first_done;
        logic          valid;
        ing_phy_beat_t beat;
    } drive_t;

    logic                               ing_phys_ports;
    logic                               reset;
    logic [NUM_PORTS-1:0]               phy_valid;
    ing_phy_beat_t                      phy_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0]               port_enable;
    logic [NUM_PORTS-1:0]               cnt_clear;
    logic [NUM_PORTS-1:0]               out_ready;
    logic [NUM_PORTS-1:0]               out_valid;
    ing_bus_word_t                      out_word [NUM_PORTS];
    logic [NUM_CNTS-1:0][CNT_WIDTH-1:0] counts [NUM_PORTS];
    logic [NUM_PORTS-1:0]               connected;
    logic [NUM_PORTS-1:0]               buf_full_drop;

    // Reference model state
    drive_t                             beat_q      [NUM_PORTS][$];
    ing_bus_word_t                      frame_words [NUM_PORTS][$];
    int                                 frame_len   [NUM_PORTS][$];
    int                                 frame_bytes [NUM_PORTS][$];
    ing_bus_word_t                      exp_q       [NUM_PORTS][$];
    logic [NUM_CNTS-1:0][CNT_WIDTH-1:0] exp_cnt [NUM_PORTS];
    int                                 occ [NUM_PORTS];
    int                                 ready_mode [NUM_PORTS];
    logic [NUM_PORTS-1:0]               en_want;
    logic [NUM_PORTS-1:0]               decide_pend;
    logic [NUM_PORTS-1:0]               bfd_due;
    logic [15:0]                        lfsr_state;
    int word_errs  = 0;
    int cnt_errs   = 0;
    int bit_errs   = 0;
    int other_errs = 0;

    ing_port_array_adapt #(
        .NUM_PORTS       (NUM_PORTS),
        .FIFO_DEPTH      (FIFO_DEPTH),
        .MAX_FRAME_WORDS (MAX_FRAME_WORDS),
        .CNT_WIDTH       (CNT_WIDTH)
    ) u_dut (
        .ing_phys_ports (ing_phys_ports),
        .reset          (reset),
        .phy_valid      (phy_valid),
        .phy_beat       (phy_beat),
        .port_enable    (port_enable),
        .cnt_clear      (cnt_clear),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .out_word       (out_word),
        .counts         (counts),
        .connected      (connected),
        .buf_full_drop  (buf_full_drop)
    );

    initial ing_phys_ports = 1'b0;
    always #5 ing_phys_ports = ~ing_phys_ports;

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks

    // Data compared only under keep
    task automatic check_word(input ing_bus_word_t got, input ing_bus_word_t exp,
                              input string name);
        logic [BUS_BYTES*8-1:0] mask;
        for (int i = 0; i < BUS_BYTES; i++) begin
            mask[i*8 +: 8] = {8{exp.keep[i]}};
        end
        if (got.keep !== exp.keep || got.last !== exp.last ||
            ((got.data ^ exp.data) & mask) !== '0) begin
            word_errs++;
            $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input logic [CNT_WIDTH-1:0] got,
                               input logic [CNT_WIDTH-1:0] exp, input string name);
        if (got !== exp) begin
            cnt_errs++;
            $display("CHECK FAILED t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            bit_errs++;
            $display("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic check_counters(input int p);
        ing_cnt_idx_e idx;
        for (int i = 0; i < NUM_CNTS; i++) begin
            idx = ing_cnt_idx_e'(i);
            check_count(counts[p][i], exp_cnt[p][i],
                        $sformatf("counts[%0d].%s", p, idx.name()));
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus and model

    // Queue one frame of n beats and its packed words
    task automatic queue_frame(input int p, input int n, input logic half_last);
        drive_t        d;
        ing_bus_word_t w;
        int            lane;
        int            nw;
        int            nb;
        w  = '0;
        nw = 0;
        nb = 0;
        for (int i = 0; i < n; i++) begin
            lane            = i % BEATS_PER_WORD;
            d.valid         = 1'b1;
            d.first_done    = (i == ((n < BEATS_PER_WORD) ? n - 1 : BEATS_PER_WORD - 1));
            d.beat.data     = 16'(rand_bits(16));
            d.beat.last     = (i == n - 1);
            d.beat.keep     = (d.beat.last && half_last) ? 2'b01 : 2'b11;
            nb             += d.beat.keep[0] + d.beat.keep[1];
            w.data[lane*16 +: 16] = d.beat.data;
            w.keep[lane*2 +: 2]   = d.beat.keep;
            if (lane == BEATS_PER_WORD - 1 || d.beat.last) begin
                w.last = d.beat.last;
                frame_words[p].push_back(w);
                nw++;
                w = '0;
            end
            beat_q[p].push_back(d);
            // Idle gap between beats
            if (!d.beat.last && rand_bits(1) != 0) begin
                beat_q[p].push_back('0);
            end
        end
        frame_len[p].push_back(nw);
        frame_bytes[p].push_back(nb);
    endtask

    // One cycle, everything driven and sampled at the falling edge
    task automatic tick();
        drive_t        d;
        ing_bus_word_t w;
        int            n;
        int            nb;
        logic          admit;
        @(negedge ing_phys_ports);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_bit(buf_full_drop[p], bfd_due[p], $sformatf("buf_full_drop[%0d]", p));
            bfd_due[p]     = 1'b0;
            port_enable[p] = en_want[p];
            // First word of a frame reaches the gate at the coming edge
            if (decide_pend[p]) begin
                n     = frame_len[p].pop_front();
                nb    = frame_bytes[p].pop_front();
                admit = en_want[p] && (FIFO_DEPTH - occ[p] >= MAX_FRAME_WORDS);
                repeat (n) begin
                    w = frame_words[p].pop_front();
                    if (admit) begin
                        exp_q[p].push_back(w);
                    end
                end
                if (admit) begin
                    occ[p] += n;
                    exp_cnt[p][CNT_FRAMES] += 1;
                    exp_cnt[p][CNT_BYTES]  += CNT_WIDTH'(nb);
                end else if (!en_want[p]) begin
                    exp_cnt[p][CNT_DROP_DISABLED] += 1;
                end else begin
                    exp_cnt[p][CNT_DROP_FULL] += 1;
                    bfd_due[p] = 1'b1;
                end
                decide_pend[p] = 1'b0;
            end
            out_ready[p] = (ready_mode[p] == 2) ? (rand_bits(1) != 0) : (ready_mode[p] != 0);
            if (out_valid[p] && out_ready[p]) begin
                if (exp_q[p].size() == 0) begin
                    other_errs++;
                    $display("Port %0d delivered a word at %0t that no admitted frame holds",
                             p, $time);
                end else begin
                    check_word(out_word[p], exp_q[p].pop_front(), $sformatf("out_word[%0d]", p));
                    occ[p]--;
                end
            end
            d = (beat_q[p].size() != 0) ? beat_q[p].pop_front() : '0;
            phy_valid[p]   = d.valid;
            phy_beat[p]    = d.beat;
            decide_pend[p] = d.valid && d.first_done;
        end
    endtask

    // 0 stimulus sent, 1 outputs drained, 2 port 0 frame decided
    function automatic logic cond_met(input int what);
        logic ok;
        ok = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (what == 2 && p == 0 && frame_len[0].size() != 0) ok = 1'b0;
            if (what < 2 && (beat_q[p].size() != 0 || decide_pend[p])) ok = 1'b0;
            if (what == 1 && exp_q[p].size() != 0) ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic wait_for(input int what, input int limit);
        int n;
        n = 0;
        while (!cond_met(what)) begin
            if (n == limit) begin
                other_errs++;
                $display("Timeout at %0t waiting for condition %0d", $time, what);
                end_run();
            end
            tick();
            n++;
        end
    endtask

    task automatic end_run();
        $display("Errors: word %0d, count %0d, bit %0d, other %0d",
                 word_errs, cnt_errs, bit_errs, other_errs);
        if (word_errs + cnt_errs + bit_errs + other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Scenario sequence

    initial begin
        lfsr_state  = 16'd5;
        reset       = 1'b1;
        phy_valid   = '0;
        port_enable = '0;
        cnt_clear   = '0;
        out_ready   = '0;
        en_want     = '0;
        decide_pend = '0;
        bfd_due     = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            phy_beat[p]   = '0;
            exp_cnt[p]    = '0;
            occ[p]        = 0;
            ready_mode[p] = 2;
        end
        repeat (8) @(negedge ing_phys_ports);
        reset   = 1'b0;
        en_want = '1;

        // Packing and port independence under random back-pressure
        for (int i = 0; i < 24; i++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                queue_frame(p, rand_bits(3) + 1, rand_bits(1) != 0);
            end
        end
        wait_for(1, 4000);
        repeat (3) tick();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_bit(connected[p], 1'b1, $sformatf("connected[%0d]", p));
            check_bit(out_valid[p], 1'b0, $sformatf("out_valid[%0d]", p));
            check_counters(p);
        end

        // Disable port 0 in the middle of a frame
        queue_frame(0, 8, 1'b0);
        wait_for(2, 100);
        en_want[0] = 1'b0;
        repeat (2) tick();
        check_bit(connected[0], 1'b1, "connected[0]");
        for (int i = 0; i < 3; i++) begin
            queue_frame(0, rand_bits(3) + 1, rand_bits(1) != 0);
            queue_frame(1, rand_bits(3) + 1, rand_bits(1) != 0);
        end
        wait_for(1, 2000);
        repeat (3) tick();
        check_bit(connected[0], 1'b0, "connected[0]");
        check_counters(0);
        check_counters(1);

        // Fill port 0 with four-word frames while the core side stalls
        en_want[0]    = 1'b1;
        ready_mode[0] = 0;
        for (int i = 0; i < FIFO_DEPTH / MAX_FRAME_WORDS + 2; i++) begin
            queue_frame(0, MAX_FRAME_WORDS * BEATS_PER_WORD, 1'b0);
        end
        wait_for(0, 2000);
        repeat (3) tick();
        ready_mode[0] = 1;
        wait_for(1, 2000);
        repeat (3) tick();
        check_counters(0);

        // Clear affects port 0 only
        cnt_clear[0] = 1'b1;
        tick();
        cnt_clear[0] = 1'b0;
        exp_cnt[0]   = '0;
        repeat (2) tick();
        check_counters(0);
        check_counters(1);

        end_run();
    end

endmodule

/* project.f */
verilog/ing_adapt_pkg.sv
verilog/ing_width_upsizer.sv
verilog/ing_frame_gate.sv
verilog/ing_frame_fifo.sv
verilog/ing_port_counters.sv
verilog/ing_port_array_adapt.sv
dv/ing_adapt_tb.sv
